/* verilog.f */
common/ingress_pkg.sv
rtl/port_rx/port_rx_packer.sv
rtl/pkt_buffer/pkt_buffer.sv
rtl/converged_bus_arbiter.sv
rtl/router_ingress.sv
sim/router_ingress_checker.sv
sim/router_ingress_tb.sv

/* Makefile */
# Verilator build for the router ingress testbench

VERILATOR ?= verilator
TOP       ?= router_ingress_tb
FILE_LIST ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing -j 0
PASS_TEXT ?= >>> PASS

.PHONY: all lint sim build clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILE_LIST)

sim: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '$(PASS_TEXT)'

clean:
	rm -rf $(BUILD_DIR)

/* sim/router_ingress_tb.sv */
/* Router ingress testbench
   Clock, reset and a stimulus table applied to the ingress top level */

`timescale 1ns/1ps

module router_ingress_tb;

    localparam int np = ingress_pkg::num_ports;
    localparam int wait_limit = 20000;

    // Ready modes
    localparam logic [1:0] rdy_random = 2'd0;
    localparam logic [1:0] rdy_low    = 2'd1;
    localparam logic [1:0] rdy_high   = 2'd2;

    typedef struct packed {
        int         port;
        int         len;
        logic [3:0] mask;
        logic [1:0] rdy;
        logic       clr;
        logic       dlv;
    } row_t;

    localparam int num_rows = 27;

    row_t rows [num_rows] = '{
        // Length sweep
        '{0, 1, 4'hf, rdy_high, 1'b0, 1'b1}, '{1, 3, 4'hf, rdy_high, 1'b0, 1'b1},
        '{2, 4, 4'hf, rdy_high, 1'b0, 1'b1}, '{3, 5, 4'hf, rdy_high, 1'b0, 1'b1},
        '{0, 8, 4'hf, rdy_high, 1'b0, 1'b1}, '{1, 63, 4'hf, rdy_high, 1'b0, 1'b1},
        '{2, 256, 4'hf, rdy_high, 1'b0, 1'b1}, '{3, 256, 4'hf, rdy_high, 1'b0, 1'b1},
        // Interleaved ports, one disabled packet on port 1
        '{0, 16, 4'hf, rdy_high, 1'b0, 1'b1}, '{1, 40, 4'hf, rdy_high, 1'b0, 1'b1},
        '{2, 24, 4'hf, rdy_high, 1'b0, 1'b1}, '{3, 12, 4'hf, rdy_high, 1'b0, 1'b1},
        '{0, 33, 4'hf, rdy_high, 1'b0, 1'b1}, '{1, 20, 4'hd, rdy_high, 1'b0, 1'b0},
        '{2, 7, 4'hf, rdy_high, 1'b0, 1'b1}, '{3, 64, 4'hf, rdy_high, 1'b0, 1'b1},
        '{1, 9, 4'hf, rdy_high, 1'b0, 1'b1},
        // Counter clear
        '{2, 0, 4'hf, rdy_high, 1'b1, 1'b0},
        // Random back-pressure
        '{0, 100, 4'hf, rdy_random, 1'b0, 1'b1}, '{1, 50, 4'hf, rdy_random, 1'b0, 1'b1},
        '{2, 256, 4'hf, rdy_random, 1'b0, 1'b1}, '{3, 13, 4'hf, rdy_random, 1'b0, 1'b1},
        // Ready held low, third packet overflows
        '{0, 256, 4'hf, rdy_low, 1'b0, 1'b1}, '{0, 256, 4'hf, rdy_low, 1'b0, 1'b1},
        '{0, 256, 4'hf, rdy_low, 1'b0, 1'b0},
        '{3, 2, 4'hf, rdy_high, 1'b0, 1'b1}, '{2, 11, 4'hf, rdy_high, 1'b0, 1'b1}
    };

    logic                    core_clk_ifc = 1'b0;
    logic                    rst_n = 1'b0;
    ingress_pkg::port_data_t port_tdata    [np] = '{default: '0};
    ingress_pkg::port_keep_t port_tkeep    [np] = '{default: '0};
    logic                    port_tvalid   [np] = '{default: 1'b0};
    logic                    port_tlast    [np] = '{default: 1'b0};
    logic                    port_enable   [np] = '{default: 1'b1};
    logic                    cnt_clear     [np] = '{default: 1'b0};
    ingress_pkg::frame_cnt_t frame_cnt     [np];
    logic                    buf_full_drop [np];
    ingress_pkg::bus_data_t  ing_tdata;
    ingress_pkg::bus_keep_t  ing_tkeep;
    ingress_pkg::port_idx_t  ing_tuser;
    logic                    ing_tvalid;
    logic                    ing_tlast;
    logic                    ing_tready = 1'b0;

    int         seed = 58655;
    logic [1:0] ready_mode = rdy_high;
    logic       busy [np] = '{default: 1'b0};
    int         model_cnt [np] = '{default: 0};
    bit         timed_out = 1'b0;

    always #4 core_clk_ifc = ~core_clk_ifc;

    router_ingress router_ingress_i (
        .clk (core_clk_ifc), .rst_n (rst_n),
        .port_tdata (port_tdata), .port_tkeep (port_tkeep),
        .port_tvalid (port_tvalid), .port_tlast (port_tlast),
        .port_enable (port_enable), .cnt_clear (cnt_clear),
        .frame_cnt (frame_cnt), .buf_full_drop (buf_full_drop),
        .ing_tdata (ing_tdata), .ing_tkeep (ing_tkeep), .ing_tuser (ing_tuser),
        .ing_tvalid (ing_tvalid), .ing_tlast (ing_tlast), .ing_tready (ing_tready)
    );

    router_ingress_checker checker_i (
        .clk (core_clk_ifc), .rst_n (rst_n),
        .ing_tdata (ing_tdata), .ing_tkeep (ing_tkeep), .ing_tuser (ing_tuser),
        .ing_tvalid (ing_tvalid), .ing_tlast (ing_tlast), .ing_tready (ing_tready),
        .buf_full_drop (buf_full_drop)
    );

    // Bus back-pressure
    always @(negedge core_clk_ifc) begin
        if (ready_mode == rdy_random) begin
            ing_tready = ($random(seed) & 1) != 0;
        end else begin
            ing_tready = (ready_mode == rdy_high);
        end
    end

    function automatic logic [7:0] pkt_byte(int n, int i, int p);
        int v;
        v = n * 16 + i + p * 64;
        return v[7:0];
    endfunction

    task automatic finish_run();
        checker_i.print_summary();
        if (!timed_out && checker_i.error_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    endtask

    task automatic send_packet(int p, int len, int n, logic [3:0] mask);
        int beats;
        int gap;
        int idx;
        beats = (len + 3) / 4;
        @(negedge core_clk_ifc);
        port_enable[p] = mask[p];
        for (int b = 0; b < beats; b++) begin
            gap = $random(seed) & 3;
            port_tvalid[p] = 1'b0;
            repeat (gap) @(negedge core_clk_ifc);
            for (int k = 0; k < 4; k++) begin
                idx = b * 4 + k;
                port_tdata[p][8*k +: 8] = (idx < len) ? pkt_byte(n, idx, p) : 8'h00;
                port_tkeep[p][k] = (idx < len);
            end
            port_tlast[p]  = (b == beats - 1);
            port_tvalid[p] = 1'b1;
            @(negedge core_clk_ifc);
        end
        port_tvalid[p] = 1'b0;
        port_tlast[p]  = 1'b0;
        busy[p] = 1'b0;
    endtask

    task automatic wait_port_idle(int p);
        int t;
        t = 0;
        while (busy[p] && !timed_out) begin
            @(negedge core_clk_ifc);
            t++;
            if (t > wait_limit) begin
                $display("Timeout: sender on port %0d never finished its packet", p);
                timed_out = 1'b1;
            end
        end
    endtask

    task automatic wait_drain();
        int t;
        t = 0;
        for (int p = 0; p < np; p++) begin
            wait_port_idle(p);
        end
        while (!timed_out && (checker_i.pending() != 0 || ing_tvalid)) begin
            @(negedge core_clk_ifc);
            t++;
            if (t > wait_limit) begin
                $display("Timeout: expected packets never left the converged bus");
                timed_out = 1'b1;
            end
        end
        repeat (2) @(negedge core_clk_ifc);
    endtask

    task automatic compare_counts();
        for (int p = 0; p < np; p++) begin
            checker_i.compare_value($sformatf("frame_cnt[%0d]", p),
                64'(model_cnt[p]), 64'(frame_cnt[p]));
        end
    endtask

    //////////////////////////////
    // Table loop

    initial begin
        repeat (10) @(negedge core_clk_ifc);
        rst_n = 1'b1;
        repeat (2) @(negedge core_clk_ifc);
        for (int r = 0; r < num_rows && !timed_out; r++) begin : row_loop
            automatic int         rn = r;
            automatic int         rp = rows[r].port;
            automatic int         rl = rows[r].len;
            automatic logic [3:0] rm = rows[r].mask;
            if (rows[r].rdy != ready_mode) begin
                if (ready_mode != rdy_low) begin
                    wait_drain();
                end else begin
                    // Overflow packet finishes while the bus is still stalled
                    for (int p = 0; p < np; p++) begin
                        wait_port_idle(p);
                    end
                end
                ready_mode = rows[r].rdy;
            end
            if (rows[r].clr) begin
                wait_drain();
                compare_counts();
                cnt_clear[rp] = 1'b1;
                @(negedge core_clk_ifc);
                cnt_clear[rp] = 1'b0;
                model_cnt[rp] = 0;
                compare_counts();
            end else begin
                // Large and random-ready packets go out one at a time
                if (ready_mode == rdy_random || (ready_mode == rdy_high && rl > 64)) begin
                    wait_drain();
                end
                wait_port_idle(rp);
                if (rows[r].dlv) begin
                    checker_i.expect_packet(rp, rl, rn);
                end
                if (rm[rp]) begin
                    model_cnt[rp]++;
                end
                busy[rp] = 1'b1;
                fork
                    send_packet(rp, rl, rn, rm);
                join_none
            end
        end
        wait_drain();
        compare_counts();
        for (int p = 0; p < np; p++) begin
            checker_i.compare_value($sformatf("buf_full_drop[%0d] pulses", p),
                64'(p == 0 ? 1 : 0), 64'(checker_i.drop_count[p]));
        end
        finish_run();
    end

endmodule

/* sim/router_ingress_checker.sv */
/* Router ingress checker
   Rebuilds packets on the converged bus and compares them with the expected ones */

`timescale 1ns/1ps

module router_ingress_checker (
    input logic                   clk,
    input logic                   rst_n,
    input ingress_pkg::bus_data_t ing_tdata,
    input ingress_pkg::bus_keep_t ing_tkeep,
    input ingress_pkg::port_idx_t ing_tuser,
    input logic                   ing_tvalid,
    input logic                   ing_tlast,
    input logic                   ing_tready,
    input logic                   buf_full_drop [ingress_pkg::num_ports]
);

    // Expected packets per port, as length and packet number
    int exp_len_q [ingress_pkg::num_ports][$];
    int exp_num_q [ingress_pkg::num_ports][$];

    int error_count = 0;
    int packet_count = 0;
    int drop_count [ingress_pkg::num_ports] = '{default: 0};

    int word_idx = 0;
    int cur_port = 0;
    int exp_len;
    int exp_num;
    int rem;
    int byte_cnt;
    logic [7:0] exp_keep;

    function automatic logic [7:0] pkt_byte(int n, int i, int p);
        int v;
        v = n * 16 + i + p * 64;
        return v[7:0];
    endfunction

    task automatic expect_packet(int p, int len, int n);
        exp_len_q[p].push_back(len);
        exp_num_q[p].push_back(n);
    endtask

    function automatic int pending();
        int total;
        total = 0;
        for (int p = 0; p < ingress_pkg::num_ports; p++) begin
            total += exp_len_q[p].size();
        end
        return total;
    endfunction

    task automatic compare_value(string name, logic [63:0] exp, logic [63:0] act);
        if (exp !== act) begin
            $display("** Error %s: expected %h, got %h", name, exp, act);
            error_count++;
        end
    endtask

    task automatic print_summary();
        $display("Checker: %0d packets received, %0d errors", packet_count, error_count);
    endtask

    //////////////////////////////
    // Bus monitor

    always @(posedge clk) begin
        if (rst_n) begin
            for (int p = 0; p < ingress_pkg::num_ports; p++) begin
                if (buf_full_drop[p]) begin
                    drop_count[p]++;
                end
            end
            if (ing_tvalid && ing_tready) begin
                if (word_idx != 0 && int'(ing_tuser) != cur_port) begin
                    compare_value("ing_tuser", 64'(cur_port), 64'(ing_tuser));
                end
                cur_port = int'(ing_tuser);
                if (exp_len_q[cur_port].size() == 0) begin
                    $display("Unexpected word on the bus from port %0d", cur_port);
                    error_count++;
                    word_idx = ing_tlast ? 0 : word_idx + 1;
                end else begin
                    exp_len = exp_len_q[cur_port][0];
                    exp_num = exp_num_q[cur_port][0];
                    rem = exp_len - word_idx * 8;
                    exp_keep = (rem >= 8) ? 8'hff : 8'((9'h1 << rem) - 9'h1);
                    compare_value("ing_tkeep", 64'(exp_keep), 64'(ing_tkeep));
                    compare_value("ing_tlast", 64'(rem <= 8), 64'(ing_tlast));
                    for (int k = 0; k < 8; k++) begin
                        if (exp_keep[k]) begin
                            compare_value("ing_tdata",
                                64'(pkt_byte(exp_num, word_idx * 8 + k, cur_port)),
                                64'(ing_tdata[8*k +: 8]));
                        end
                    end
                    if (ing_tlast) begin
                        // Byte count from words before last plus keep ones
                        byte_cnt = word_idx * 8 + $countones(ing_tkeep);
                        compare_value("packet length", 64'(exp_len), 64'(byte_cnt));
                        void'(exp_len_q[cur_port].pop_front());
                        void'(exp_num_q[cur_port].pop_front());
                        packet_count++;
                        word_idx = 0;
                    end else begin
                        word_idx++;
                    end
                end
            end
        end
    end

endmodule

/* rtl/router_ingress.sv */
/* Router ingress top
   Four port packers and packet buffers merged onto one converged bus */

`timescale 1ns/1ps

module router_ingress (
    input  logic                    clk,
    input  logic                    rst_n,
    input  ingress_pkg::port_data_t port_tdata    [ingress_pkg::num_ports],
    input  ingress_pkg::port_keep_t port_tkeep    [ingress_pkg::num_ports],
    input  logic                    port_tvalid   [ingress_pkg::num_ports],
    input  logic                    port_tlast    [ingress_pkg::num_ports],
    input  logic                    port_enable   [ingress_pkg::num_ports],
    input  logic                    cnt_clear     [ingress_pkg::num_ports],
    output ingress_pkg::frame_cnt_t frame_cnt     [ingress_pkg::num_ports],
    output logic                    buf_full_drop [ingress_pkg::num_ports],
    output ingress_pkg::bus_data_t  ing_tdata,
    output ingress_pkg::bus_keep_t  ing_tkeep,
    output ingress_pkg::port_idx_t  ing_tuser,
    output logic                    ing_tvalid,
    output logic                    ing_tlast,
    input  logic                    ing_tready
);

    // Packer to buffer
    ingress_pkg::bus_data_t wr_data  [ingress_pkg::num_ports];
    ingress_pkg::bus_keep_t wr_keep  [ingress_pkg::num_ports];
    logic                   wr_last  [ingress_pkg::num_ports];
    logic                   wr_valid [ingress_pkg::num_ports];

    // Buffer to arbiter
    logic                   pkt_avail [ingress_pkg::num_ports];
    ingress_pkg::bus_data_t rd_data   [ingress_pkg::num_ports];
    ingress_pkg::bus_keep_t rd_keep   [ingress_pkg::num_ports];
    logic                   rd_last   [ingress_pkg::num_ports];
    logic                   rd_en     [ingress_pkg::num_ports];

    for (genvar p = 0; p < ingress_pkg::num_ports; p++) begin : g_port
        port_rx_packer port_rx_packer_i (
            .clk         (clk),
            .rst_n       (rst_n),
            .port_tdata  (port_tdata[p]),
            .port_tkeep  (port_tkeep[p]),
            .port_tvalid (port_tvalid[p]),
            .port_tlast  (port_tlast[p]),
            .port_enable (port_enable[p]),
            .cnt_clear   (cnt_clear[p]),
            .frame_cnt   (frame_cnt[p]),
            .wr_data     (wr_data[p]),
            .wr_keep     (wr_keep[p]),
            .wr_last     (wr_last[p]),
            .wr_valid    (wr_valid[p])
        );

        pkt_buffer pkt_buffer_i (
            .clk           (clk),
            .rst_n         (rst_n),
            .wr_data       (wr_data[p]),
            .wr_keep       (wr_keep[p]),
            .wr_last       (wr_last[p]),
            .wr_valid      (wr_valid[p]),
            .rd_en         (rd_en[p]),
            .pkt_avail     (pkt_avail[p]),
            .rd_data       (rd_data[p]),
            .rd_keep       (rd_keep[p]),
            .rd_last       (rd_last[p]),
            .buf_full_drop (buf_full_drop[p])
        );
    end

    converged_bus_arbiter converged_bus_arbiter_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .pkt_avail  (pkt_avail),
        .rd_data    (rd_data),
        .rd_keep    (rd_keep),
        .rd_last    (rd_last),
        .rd_en      (rd_en),
        .ing_tdata  (ing_tdata),
        .ing_tkeep  (ing_tkeep),
        .ing_tuser  (ing_tuser),
        .ing_tvalid (ing_tvalid),
        .ing_tlast  (ing_tlast),
        .ing_tready (ing_tready)
    );

endmodule

/* rtl/converged_bus_arbiter.sv */
/* Converged bus arbiter
   Round-robin, packet-granular merge of the port buffers, source port on tuser */

`timescale 1ns/1ps

module converged_bus_arbiter (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   pkt_avail [ingress_pkg::num_ports],
    input  ingress_pkg::bus_data_t rd_data   [ingress_pkg::num_ports],
    input  ingress_pkg::bus_keep_t rd_keep   [ingress_pkg::num_ports],
    input  logic                   rd_last   [ingress_pkg::num_ports],
    output logic                   rd_en     [ingress_pkg::num_ports],
    output ingress_pkg::bus_data_t ing_tdata,
    output ingress_pkg::bus_keep_t ing_tkeep,
    output ingress_pkg::port_idx_t ing_tuser,
    output logic                   ing_tvalid,
    output logic                   ing_tlast,
    input  logic                   ing_tready
);

    ingress_pkg::arb_state_t state;
    ingress_pkg::port_idx_t  grant;
    ingress_pkg::port_idx_t  last_served;
    ingress_pkg::port_idx_t  next_port;
    logic                    next_found;
    logic                    xfer;

    //////////////////////////////
    // Round-robin search

    // Starts one past the port served last, wraps around
    always_comb begin
        ingress_pkg::port_idx_t cand;
        next_found = 1'b0;
        next_port  = last_served;
        for (int i = 1; i <= ingress_pkg::num_ports; i++) begin
            cand = ingress_pkg::port_idx_t'(int'(last_served) + i);
            if (!next_found && pkt_avail[cand]) begin
                next_found = 1'b1;
                next_port  = cand;
            end
        end
    end

    //////////////////////////////
    // Grant FSM

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= ingress_pkg::arb_idle;
            grant       <= '0;
            last_served <= ingress_pkg::port_idx_t'(ingress_pkg::num_ports - 1);
        end else begin
            case (state)
                ingress_pkg::arb_idle: begin
                    if (next_found) begin
                        grant <= next_port;
                        state <= ingress_pkg::arb_send;
                    end
                end
                ingress_pkg::arb_send: begin
                    // Grant held until the last word goes out
                    if (xfer && rd_last[grant]) begin
                        last_served <= grant;
                        state       <= ingress_pkg::arb_idle;
                    end
                end
                default: state <= ingress_pkg::arb_idle;
            endcase
        end
    end

    //////////////////////////////
    // Bus drive

    assign ing_tvalid = (state == ingress_pkg::arb_send);
    assign xfer       = ing_tvalid && ing_tready;

    // Buffer head is stable until popped, so the bus holds under back-pressure
    assign ing_tdata = rd_data[grant];
    assign ing_tkeep = rd_keep[grant];
    assign ing_tlast = rd_last[grant];
    assign ing_tuser = grant;

    always_comb begin
        for (int p = 0; p < ingress_pkg::num_ports; p++) begin
            rd_en[p] = xfer && (grant == ingress_pkg::port_idx_t'(p));
        end
    end

endmodule

/* rtl/pkt_buffer/pkt_buffer.sv */
/* Per-port store-and-forward packet buffer
   Word FIFO that drops whole packets when it lacks room for an MTU */

`timescale 1ns/1ps

module pkt_buffer (
    input  logic                   clk,
    input  logic                   rst_n,
    input  ingress_pkg::bus_data_t wr_data,
    input  ingress_pkg::bus_keep_t wr_keep,
    input  logic                   wr_last,
    input  logic                   wr_valid,
    input  logic                   rd_en,
    output logic                   pkt_avail,
    output ingress_pkg::bus_data_t rd_data,
    output ingress_pkg::bus_keep_t rd_keep,
    output logic                   rd_last,
    output logic                   buf_full_drop
);

    ingress_pkg::bus_data_t mem_data [ingress_pkg::buf_words];
    ingress_pkg::bus_keep_t mem_keep [ingress_pkg::buf_words];
    logic                   mem_last [ingress_pkg::buf_words];

    ingress_pkg::buf_addr_t wr_ptr;
    ingress_pkg::buf_addr_t rd_ptr;
    logic [6:0]             fill_level;
    logic [6:0]             pkt_cnt;

    logic                   wr_in_pkt;
    logic                   dropping;
    logic                   first_word;
    logic                   space_ok;
    logic                   wr_en;
    logic                   pkt_in;
    logic                   pkt_out;

    //////////////////////////////
    // Drop decision

    assign first_word = wr_valid && !wr_in_pkt;

    // Room for a full MTU packet, whatever length this one turns out to be
    assign space_ok = (7'(ingress_pkg::buf_words) - fill_level) >= 7'(ingress_pkg::mtu_words);

    assign wr_en = wr_valid && (first_word ? space_ok : !dropping);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_in_pkt     <= 1'b0;
            dropping      <= 1'b0;
            buf_full_drop <= 1'b0;
        end else begin
            buf_full_drop <= first_word && !space_ok;
            if (wr_valid) begin
                wr_in_pkt <= !wr_last;
                if (first_word) begin
                    dropping <= !space_ok;
                end
            end
        end
    end

    //////////////////////////////
    // Storage

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem_data[wr_ptr] <= wr_data;
            mem_keep[wr_ptr] <= wr_keep;
            mem_last[wr_ptr] <= wr_last;
        end
    end

    // Head word falls through
    assign rd_data = mem_data[rd_ptr];
    assign rd_keep = mem_keep[rd_ptr];
    assign rd_last = mem_last[rd_ptr];

    //////////////////////////////
    // Pointers and counts

    assign pkt_in  = wr_en && wr_last;
    assign pkt_out = rd_en && rd_last;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            fill_level <= '0;
            pkt_cnt    <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + ingress_pkg::buf_addr_t'(1);
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + ingress_pkg::buf_addr_t'(1);
            end
            case ({wr_en, rd_en})
                2'b10:   fill_level <= fill_level + 7'd1;
                2'b01:   fill_level <= fill_level - 7'd1;
                default: ;
            endcase
            case ({pkt_in, pkt_out})
                2'b10:   pkt_cnt <= pkt_cnt + 7'd1;
                2'b01:   pkt_cnt <= pkt_cnt - 7'd1;
                default: ;
            endcase
        end
    end

    // Only complete packets are offered
    assign pkt_avail = (pkt_cnt != 7'd0);

endmodule

/* rtl/port_rx/port_rx_packer.sv */
/* Port receive packer
   Enable gating, frame counting and 32-to-64-bit beat packing for one port */

`timescale 1ns/1ps

module port_rx_packer (
    input  logic                    clk,
    input  logic                    rst_n,
    input  ingress_pkg::port_data_t port_tdata,
    input  ingress_pkg::port_keep_t port_tkeep,
    input  logic                    port_tvalid,
    input  logic                    port_tlast,
    input  logic                    port_enable,
    input  logic                    cnt_clear,
    output ingress_pkg::frame_cnt_t frame_cnt,
    output ingress_pkg::bus_data_t  wr_data,
    output ingress_pkg::bus_keep_t  wr_keep,
    output logic                    wr_last,
    output logic                    wr_valid
);

    logic                    in_pkt;
    logic                    pkt_drop;
    logic                    first_beat;
    logic                    beat_accept;

    // Odd beat waiting for its partner
    logic                    half_valid;
    ingress_pkg::port_data_t half_data;
    ingress_pkg::port_keep_t half_keep;

    assign first_beat = port_tvalid && !in_pkt;

    // Enable is only looked at on the first beat, later beats follow that decision
    assign beat_accept = port_tvalid && (in_pkt ? !pkt_drop : port_enable);

    //////////////////////////////
    // Packet tracking

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            in_pkt   <= 1'b0;
            pkt_drop <= 1'b0;
        end else if (port_tvalid) begin
            in_pkt <= !port_tlast;
            if (first_beat) begin
                pkt_drop <= !port_enable;
            end
        end
    end

    //////////////////////////////
    // Beat packing

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            half_valid <= 1'b0;
        end else if (beat_accept) begin
            // A last beat always flushes, so the next packet starts on a clean pair
            half_valid <= !half_valid && !port_tlast;
        end
    end

    always_ff @(posedge clk) begin
        if (beat_accept && !half_valid) begin
            half_data <= port_tdata;
            half_keep <= port_tkeep;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_valid <= 1'b0;
        end else begin
            wr_valid <= beat_accept && (half_valid || port_tlast);
        end
    end

    always_ff @(posedge clk) begin
        if (beat_accept) begin
            wr_last <= port_tlast;
            if (half_valid) begin
                // First beat sits in the low half
                wr_data <= {port_tdata, half_data};
                wr_keep <= {port_tkeep, half_keep};
            end else begin
                // Lone last beat, upper half empty
                wr_data <= {ingress_pkg::port_data_t'('0), port_tdata};
                wr_keep <= {ingress_pkg::port_keep_t'('0), port_tkeep};
            end
        end
    end

    //////////////////////////////
    // Frame counter

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            frame_cnt <= '0;
        end else if (cnt_clear) begin
            frame_cnt <= '0;
        end else if (beat_accept && port_tlast) begin
            frame_cnt <= frame_cnt + 32'd1;
        end
    end

endmodule

/* common/ingress_pkg.sv */
/* Router ingress shared definitions
   Port and bus widths, buffer sizing, arbiter states */

package ingress_pkg;

    //////////////////////////////
    // Sizes

    localparam int num_ports = 4;

    // Largest packet, in bytes and in 64-bit bus words
    localparam int mtu_bytes = 256;
    localparam int mtu_words = mtu_bytes / 8;

    // Depth of each per-port packet buffer
    localparam int buf_words = 64;

    //////////////////////////////
    // Vector types

    typedef logic [$clog2(num_ports)-1:0] port_idx_t;

    // Physical receive port, one 32-bit beat
    typedef logic [31:0] port_data_t;
    typedef logic [3:0]  port_keep_t;

    // Converged bus, one 64-bit word
    typedef logic [63:0] bus_data_t;
    typedef logic [7:0]  bus_keep_t;

    typedef logic [$clog2(buf_words)-1:0] buf_addr_t;

    typedef logic [31:0] frame_cnt_t;

    //////////////////////////////
    // Arbiter FSM

    typedef enum logic {
        arb_idle,
        arb_send
    } arb_state_t;

endpackage
